//--- Bender.yml
package:
  name: dcache

sources:
  - hw/dcache_geom_pkg.sv
  - hw/dcache_ctrl_pkg.sv
  - hw/dcache_array_if.sv
  - hw/dcache_tag_array.sv
  - hw/dcache_data_array.sv
  - hw/dcache_ctrl.sv
  - hw/dcache.sv
  - target: test
    files:
      - testbench/dcache_props.sv
      - testbench/tb_dcache.sv

//--- dcache.f
hw/dcache_geom_pkg.sv
hw/dcache_ctrl_pkg.sv
hw/dcache_array_if.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache.sv
testbench/dcache_props.sv
testbench/tb_dcache.sv

//--- hw/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
  input  logic                   clk,
  input  logic                   rst,
  // CPU side
  input  dcache_geom_pkg::word_t addr,
  input  dcache_geom_pkg::word_t din,
  input  logic                   req,
  input  logic                   wreq,
  input  logic [3:0]             wbyte,
  output dcache_geom_pkg::word_t rdata,
  output logic                   ok,
  output logic                   miss,
  // Memory side
  output logic                   sen,
  output dcache_geom_pkg::word_t raddr,
  input  dcache_geom_pkg::word_t sdata,
  input  logic                   rdata_ok,
  output logic                   wen,
  output dcache_geom_pkg::word_t waddr,
  output dcache_geom_pkg::word_t wdata,
  input  logic                   wdata_ok
);

  dcache_array_if arr ();

  dcache_tag_array i_tag_array (
    .clk (clk),
    .rst (rst),
    .arr (arr.tags)
  );

  dcache_data_array i_data_array (
    .clk (clk),
    .arr (arr.data)
  );

  dcache_ctrl i_ctrl (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .wreq     (wreq),
    .rdata_ok (rdata_ok),
    .wdata_ok (wdata_ok),
    .addr     (addr),
    .din      (din),
    .sdata    (sdata),
    .wbyte    (wbyte),
    .rdata    (rdata),
    .raddr    (raddr),
    .waddr    (waddr),
    .wdata    (wdata),
    .ok       (ok),
    .miss     (miss),
    .sen      (sen),
    .wen      (wen),
    .arr      (arr.ctrl)
  );

endmodule

`default_nettype wire

//--- hw/dcache_array_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if;
  import dcache_geom_pkg::*;

  // Driven by the controller
  index_t     index;
  tag_t       lookup_tag;
  way_t       way;
  offset_t    word;
  logic [3:0] byte_en;
  word_t      wdata;
  logic       touch;
  logic       is_write;
  logic       fill;

  // Driven by the arrays
  logic       hit;
  way_t       hit_way;
  way_t       victim_way;
  logic       victim_dirty;
  word_t      victim_addr;
  word_t      rdata;

  modport ctrl (
    output index, lookup_tag, way, word, byte_en, wdata, touch, is_write, fill,
    input  hit, hit_way, victim_way, victim_dirty, victim_addr, rdata
  );

  modport tags (
    input  index, lookup_tag, way, touch, is_write, fill,
    output hit, hit_way, victim_way, victim_dirty, victim_addr
  );

  modport data (
    input  index, way, word, byte_en, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  logic                   wreq,
  input  logic                   rdata_ok,
  input  logic                   wdata_ok,
  input  dcache_geom_pkg::word_t addr,
  input  dcache_geom_pkg::word_t din,
  input  dcache_geom_pkg::word_t sdata,
  input  logic [3:0]             wbyte,
  output dcache_geom_pkg::word_t rdata,
  output dcache_geom_pkg::word_t raddr,
  output dcache_geom_pkg::word_t waddr,
  output dcache_geom_pkg::word_t wdata,
  output logic                   ok,
  output logic                   miss,
  output logic                   sen,
  output logic                   wen,
  dcache_array_if.ctrl           arr
);
  import dcache_geom_pkg::*;
  import dcache_ctrl_pkg::*;

  ctrl_state_e       state;
  logic [BEAT_W-1:0] beat;
  logic              last_beat;
  addr_u             req_addr;
  addr_u             cur_addr;
  logic              req_wr;
  logic [3:0]        req_be;
  word_t             req_din;
  way_t              req_way;

  assign cur_addr.raw = (state == IDLE) ? addr : req_addr.raw;
  assign last_beat    = (beat == BEAT_W'(LINE_WORDS - 1));

  assign miss  = (state != IDLE);
  assign wen   = (state == WRITE_BACK);
  assign sen   = (state == REFILL);
  assign wdata = arr.rdata;         // Victim word at current beat
  assign raddr = {req_addr.f.tag, req_addr.f.index, {(OFFSET_W + 2){1'b0}}};

  ////////////////////////////////////////////////////////////////////////////
  // Array port steering

  always_comb
  begin
    arr.index      = cur_addr.f.index;
    arr.lookup_tag = cur_addr.f.tag;
    arr.way        = req_way;
    arr.word       = cur_addr.f.offset;
    arr.byte_en    = '0;
    arr.wdata      = req_din;
    arr.touch      = 1'b0;
    arr.is_write   = req_wr;
    arr.fill       = 1'b0;
    case (state)
      IDLE:
      begin
        arr.way      = arr.hit_way;
        arr.wdata    = din;
        arr.is_write = wreq;
        if (req && arr.hit)
        begin
          arr.touch = 1'b1;
          if (wreq)
            arr.byte_en = wbyte;
        end
      end
      WRITE_BACK:
        arr.word = beat;
      REFILL:
      begin
        arr.word  = beat;
        arr.wdata = sdata;
        if (rdata_ok)
          arr.byte_en = 4'hf;
      end
      default:
      begin
        // FINISH: new tag plus the pending access
        arr.touch = 1'b1;
        arr.fill  = 1'b1;
        if (req_wr)
          arr.byte_en = req_be;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Miss sequencing

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= IDLE;
      beat  <= '0;
      ok    <= 1'b0;
    end
    else
    begin
      ok <= 1'b0;
      case (state)
        IDLE:
        begin
          if (req && arr.hit)
            ok <= 1'b1;
          else if (req)
          begin
            state <= arr.victim_dirty ? WRITE_BACK : REFILL;
            beat  <= '0;
          end
        end
        WRITE_BACK:
        begin
          if (wdata_ok)
          begin
            beat <= beat + 1'b1;       // Wraps to 0 for the refill
            if (last_beat)
              state <= REFILL;
          end
        end
        REFILL:
        begin
          if (rdata_ok)
          begin
            beat <= beat + 1'b1;
            if (last_beat)
              state <= FINISH;
          end
        end
        default:
        begin
          ok    <= 1'b1;
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
    begin
      req_addr.raw <= addr;
      req_wr       <= wreq;
      req_be       <= wbyte;
      req_din      <= din;
      req_way      <= arr.victim_way;
      waddr        <= arr.victim_addr;
      rdata        <= wreq ? din : arr.rdata; // Used only on a hit
    end
    else if (state == FINISH)
      rdata <= req_wr ? req_din : arr.rdata;
  end

endmodule

`default_nettype wire

//--- hw/dcache_ctrl_pkg.sv
`default_nettype none

package dcache_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK,
    REFILL,
    FINISH
  } ctrl_state_e;

  localparam int BEAT_W = 4; // One beat per line word

endpackage

`default_nettype wire

//--- hw/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
  input logic          clk,
  dcache_array_if.data arr
);
  import dcache_geom_pkg::*;

  localparam int SETS = 2 ** INDEX_W;

  word_t mem [WAYS][SETS][LINE_WORDS];

  // Single port, byte lanes written independently
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < 4; b++)
    begin
      if (arr.byte_en[b])
        mem[arr.way][arr.index][arr.word][8*b +: 8] <= arr.wdata[8*b +: 8];
    end
  end

  assign arr.rdata = mem[arr.way][arr.index][arr.word]; // Async read

endmodule

`default_nettype wire

//--- hw/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

  localparam int WAYS       = 4;
  localparam int LINE_WORDS = 16;
  localparam int INDEX_W    = 4;
  localparam int OFFSET_W   = 4;
  localparam int TAG_W      = 22;

  typedef logic [1:0]          way_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [31:0]         word_t;

  // Byte address split for lookup
  typedef struct packed {
    tag_t       tag;
    index_t     index;
    offset_t    offset;
    logic [1:0] byte_off;
  } addr_fields_t;

  typedef union packed {
    word_t        raw;
    addr_fields_t f;
  } addr_u;

endpackage

`default_nettype wire

//--- hw/dcache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
  input logic          clk,
  input logic          rst,
  dcache_array_if.tags arr
);
  import dcache_geom_pkg::*;

  localparam int SETS = 2 ** INDEX_W;

  tag_t            tag_mem [WAYS][SETS];
  way_t            age     [WAYS][SETS];
  logic [SETS-1:0] valid   [WAYS];
  logic [SETS-1:0] dirty   [WAYS];
  way_t            touched_age;
  addr_u           va;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup and victim choice

  always_comb
  begin
    arr.hit     = 1'b0;
    arr.hit_way = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (valid[w][arr.index] && tag_mem[w][arr.index] == arr.lookup_tag)
      begin
        arr.hit     = 1'b1;
        arr.hit_way = way_t'(w);
      end
    end
  end

  // Oldest way first, then lowest invalid way overrides
  always_comb
  begin
    arr.victim_way = '0;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (age[w][arr.index] == way_t'(WAYS - 1))
        arr.victim_way = way_t'(w);
    end
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (!valid[w][arr.index])
        arr.victim_way = way_t'(w);
    end
  end

  always_comb
  begin
    va.f.tag      = tag_mem[arr.victim_way][arr.index];
    va.f.index    = arr.index;
    va.f.offset   = '0;           // Line base
    va.f.byte_off = '0;
  end

  assign arr.victim_addr  = va.raw;
  assign arr.victim_dirty = valid[arr.victim_way][arr.index] & dirty[arr.victim_way][arr.index];
  assign touched_age      = age[arr.way][arr.index];

  ////////////////////////////////////////////////////////////////////////////
  // State update

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
        for (int s = 0; s < SETS; s++)
          age[w][s] <= way_t'(w);
      end
    end
    else
    begin
      if (arr.fill)
      begin
        valid[arr.way][arr.index] <= 1'b1;
        dirty[arr.way][arr.index] <= 1'b0;
      end
      if (arr.touch)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          if (age[w][arr.index] < touched_age)
            age[w][arr.index] <= age[w][arr.index] + 1'b1;
        end
        age[arr.way][arr.index] <= '0;
        if (arr.is_write)
          dirty[arr.way][arr.index] <= 1'b1; // Wins over the fill clear
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (arr.fill)
      tag_mem[arr.way][arr.index] <= arr.lookup_tag;
  end

endmodule

`default_nettype wire

//--- testbench/dcache_input.txt
# op addr wbyte din rdata miss wb
# rdata is the expected read word, or din for a write; miss and wb are 0 or 1
R 00000048 0000 00000000 5A5A0048 1 0
R 0000004C 0000 00000000 5A5A004C 0 0
W 00000050 0101 11223344 11223344 0 0
R 00000050 0000 00000000 5A220044 0 0
R 00000444 0000 00000000 5A5A0444 1 0
R 00000848 0000 00000000 5A5A0848 1 0
R 00000C4C 0000 00000000 5A5A0C4C 1 0
R 00001040 0000 00000000 5A5A1040 1 1
R 00000050 0000 00000000 5A220044 1 0
W 00000088 1100 AABBCCDD AABBCCDD 1 0
R 00000088 0000 00000000 AABB0088 0 0
W 00000C4C 1111 CAFEF00D CAFEF00D 0 0
R 00000C4C 0000 00000000 CAFEF00D 0 0
R 00001444 0000 00000000 5A5A1444 1 0
R 00001848 0000 00000000 5A5A1848 1 0
R 00001C4C 0000 00000000 5A5A1C4C 1 0
R 0000204C 0000 00000000 5A5A204C 1 1
R 00000C4C 0000 00000000 CAFEF00D 1 0

//--- testbench/dcache_props.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_props (
  input logic clk,
  input logic rst,
  input logic ok,
  input logic miss,
  input logic sen,
  input logic wen,
  input logic wdata_ok
);
  import dcache_ctrl_pkg::*;

  int unsigned     fails = 0;
  logic [BEAT_W:0] wb_count;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      wb_count <= '0;
    else if (!wen)
      wb_count <= '0;
    else if (wdata_ok)
      wb_count <= wb_count + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Port protocol

  sen_wen_apart: assert property (@(posedge clk) disable iff (rst) !(sen && wen))
    else
    begin
      fails++;
      $error("sen and wen high in the same cycle");
    end

  ok_single: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else
    begin
      fails++;
      $error("ok high for two cycles");
    end

  miss_ends_with_ok: assert property (@(posedge clk) disable iff (rst) $fell(miss) |-> ok)
    else
    begin
      fails++;
      $error("miss fell without ok");
    end

  // Full line goes out before wen drops
  wb_full_line: assert property (@(posedge clk) disable iff (rst)
    $fell(wen) |-> wb_count == (BEAT_W + 1)'(2 ** BEAT_W))
    else
    begin
      fails++;
      $error("write-back burst ended early");
    end

endmodule

bind dcache dcache_props i_props (
  .clk      (clk),
  .rst      (rst),
  .ok       (ok),
  .miss     (miss),
  .sen      (sen),
  .wen      (wen),
  .wdata_ok (wdata_ok)
);

`default_nettype wire

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
  import dcache_geom_pkg::*;

  localparam int          TIMEOUT = 2000;
  localparam logic [31:0] PATTERN = 32'h5A5A0000;

  logic       clk = 1'b0;
  logic       rst;
  word_t      addr, din, rdata, raddr, sdata, waddr, wdata;
  logic       req, wreq, ok, miss, sen, rdata_ok, wen, wdata_ok;
  logic [3:0] wbyte;

  word_t       mem [0:65535];     // Backing store, word addressed
  logic [16:0] lfsr = 17'd73050;
  int          rf_beat = 0;
  int          wb_beat = 0;
  int          rf_total = 0;
  int          wb_total = 0;
  int          errors = 0;
  int          tests = 0;
  word_t       cur_base = '0;
  logic        timed_out = 1'b0;

  always #5 clk = ~clk;

  dcache i_dcache (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .din      (din),
    .req      (req),
    .wreq     (wreq),
    .wbyte    (wbyte),
    .rdata    (rdata),
    .ok       (ok),
    .miss     (miss),
    .sen      (sen),
    .raddr    (raddr),
    .sdata    (sdata),
    .rdata_ok (rdata_ok),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata),
    .wdata_ok (wdata_ok)
  );

  // Fibonacci LFSR, taps 17 and 14
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model with random stalls

  always @(posedge clk)
  begin
    lfsr = lfsr_step(lfsr);          // One bit per cycle
    if (wen && wdata_ok)
    begin
      if (waddr[5:0] != 6'd0)
      begin
        $display("Error at %0t: waddr[5:0] is %h, expected 00", $time, waddr[5:0]);
        errors++;
      end
      mem[waddr[17:2] + wb_beat] = wdata;
      wb_beat++;
      wb_total++;
    end
    if (sen && rdata_ok)
    begin
      if (raddr !== cur_base)
      begin
        $display("Error at %0t: raddr is %h, expected %h", $time, raddr, cur_base);
        errors++;
      end
      rf_beat++;
      rf_total++;
    end
    if (!wen)
      wb_beat = 0;
    if (!sen)
      rf_beat = 0;
    sdata    <= mem[raddr[17:2] + rf_beat];
    rdata_ok <= sen & ~lfsr[0];
    wdata_ok <= wen & ~lfsr[0];
  end

  task automatic run_request(input logic is_wr, input word_t a, input logic [3:0] be,
                             input word_t d, input word_t exp_rdata, input int exp_miss,
                             input int exp_wb);
    int   cycles;
    int   rf_start;
    int   wb_start;
    int   err_start;
    logic saw_miss;
    cycles    = 0;
    saw_miss  = 1'b0;
    rf_start  = rf_total;
    wb_start  = wb_total;
    err_start = errors;
    tests++;
    @(posedge clk);
    cur_base = {a[31:6], 6'd0};
    req   <= 1'b1;
    wreq  <= is_wr;
    addr  <= a;
    wbyte <= be;
    din   <= d;
    @(posedge clk);
    req   <= 1'b0;
    wreq  <= 1'b0;
    wbyte <= 4'h0;
    @(negedge clk);
    while (!ok && cycles < TIMEOUT)
    begin
      saw_miss |= miss;
      @(negedge clk);
      cycles++;
    end
    if (!ok)
    begin
      $display("Timeout waiting for ok on request %0d after %0d cycles", tests, TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
    else
    begin
      if (rdata !== exp_rdata)
      begin
        $display("Error at %0t: rdata is %h, expected %h", $time, rdata, exp_rdata);
        errors++;
      end
      if (saw_miss != exp_miss[0])
      begin
        $display("Error at %0t: miss is %0d, expected %0d", $time, saw_miss, exp_miss);
        errors++;
      end
      if (rf_total - rf_start != (exp_miss != 0 ? 16 : 0))
      begin
        $display("Error at %0t: rdata_ok beats are %0d, expected %0d", $time,
                 rf_total - rf_start, exp_miss != 0 ? 16 : 0);
        errors++;
      end
      if (wb_total - wb_start != (exp_wb != 0 ? 16 : 0))
      begin
        $display("Error at %0t: wdata_ok beats are %0d, expected %0d", $time,
                 wb_total - wb_start, exp_wb != 0 ? 16 : 0);
        errors++;
      end
      $display("Request %0d %s %h: %s", tests, is_wr ? "W" : "R", a,
               errors == err_start ? "passed" : "failed");
    end
  endtask

  initial
  begin
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    word_t      f_addr, f_din, f_rdata;
    logic [3:0] f_wbyte;
    int         f_miss, f_wb;
    for (int i = 0; i < 65536; i++)
      mem[i] = (i * 4) ^ PATTERN;
    rst      = 1'b1;
    req      = 1'b0;
    wreq     = 1'b0;
    addr     = '0;
    din      = '0;
    wbyte    = 4'h0;
    sdata    = '0;
    rdata_ok = 1'b0;
    wdata_ok = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    fd = $fopen("testbench/dcache_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open testbench/dcache_input.txt");
      $display("ERRORS FOUND");
      $finish;
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%c %h %b %h %h %d %d", op, f_addr, f_wbyte, f_din, f_rdata,
                    f_miss, f_wb);
        if (n == 7 && (op == "R" || op == "W")) // Skips comments and blank lines
          run_request(op == "W", f_addr, f_wbyte, f_din, f_rdata, f_miss, f_wb);
      end
      $fclose(fd);
      errors += i_dcache.i_props.fails;
      $display("%0d requests, %0d errors", tests, errors);
      if (errors == 0)
        $display("NO ERRORS");
      else
        $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

`default_nettype wire
